//--- source/amo_pkg.sv
//********************
// shared types for the RV64 atomic subsystem
// xlen is fixed at 64; only .W and .D sizes exist
//********************
package amo_pkg;

    // data and address width
    localparam int xlen = 64;

    // funct5 encodings of the A extension
    typedef enum logic [4:0] {
        amo_add  = 5'b00000,
        amo_swap = 5'b00001,
        amo_lr   = 5'b00010,
        amo_sc   = 5'b00011,
        amo_xor  = 5'b00100,
        amo_or   = 5'b01000,
        amo_and  = 5'b01100,
        amo_min  = 5'b10000,
        amo_max  = 5'b10100,
        amo_minu = 5'b11000,
        amo_maxu = 5'b11100
    } amo_op_e;

    // funct3 encodings
    typedef enum logic [2:0] {
        size_w = 3'b010,
        size_d = 3'b011
    } amo_size_e;

    // one atomic request, 136 bits
    typedef struct packed {
        amo_op_e          op;
        amo_size_e        size;
        logic [xlen-1:0]  addr;
        logic [xlen-1:0]  src;
    } atomic_req_t;

    // request to the data memory, req held for the whole access
    typedef struct packed {
        logic             req;
        logic             we;
        logic [xlen-1:0]  addr;
        logic [xlen-1:0]  wdata;
        amo_size_e        size;
    } mem_req_t;

    // strobes to the reservation station
    typedef struct packed {
        logic             lr_valid;
        logic             sc_valid;
        logic [xlen-1:0]  addr;
    } rsv_req_t;

endpackage

//--- source/atomic_unit.sv
//********************
// LR/SC/AMO sequencer; start is only sampled while idle
// one request in flight, memory waits are the only stall
//********************
`timescale 1ns/1ps

module atomic_unit (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          start,
    input  amo_pkg::atomic_req_t          req,
    input  logic [amo_pkg::xlen-1:0]      mem_rdata,
    input  logic                          mem_ready,
    input  logic                          sc_success,
    output amo_pkg::mem_req_t             mem,
    output amo_pkg::rsv_req_t             rsv,
    output logic [amo_pkg::xlen-1:0]      result,
    output logic                          done,
    output logic                          busy
);

    typedef enum logic [2:0] {
        st_idle,
        st_read,
        st_wait_read,
        st_compute,
        st_write,
        st_wait_write,
        st_finish
    } state_e;

    state_e state, next_state;

    amo_pkg::atomic_req_t           cur_req;      // captured request
    logic [amo_pkg::xlen-1:0]       loaded_value;
    logic [amo_pkg::xlen-1:0]       amo_calc;
    logic [amo_pkg::xlen-1:0]       amo_wdata;    // value written by an AMO

    logic is_lr;
    logic is_sc;
    logic is_word;

    // comparison operands, .W values widened from bit 31
    logic signed [amo_pkg::xlen-1:0] ld_s;
    logic signed [amo_pkg::xlen-1:0] src_s;
    logic [amo_pkg::xlen-1:0]        ld_u;
    logic [amo_pkg::xlen-1:0]        src_u;

    assign is_lr   = (cur_req.op == amo_pkg::amo_lr);
    assign is_sc   = (cur_req.op == amo_pkg::amo_sc);
    assign is_word = (cur_req.size == amo_pkg::size_w);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= st_idle;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            st_idle: begin
                if (start) begin
                    next_state = st_read;
                end
            end
            st_read: begin
                next_state = st_wait_read;
            end
            st_wait_read: begin
                if (mem_ready) begin
                    if (is_lr) begin
                        next_state = st_finish;
                    end else if (is_sc) begin
                        // failed SC skips the write
                        next_state = sc_success ? st_write : st_finish;
                    end else begin
                        next_state = st_compute;
                    end
                end
            end
            st_compute: begin
                next_state = st_write;
            end
            st_write: begin
                next_state = st_wait_write;
            end
            st_wait_write: begin
                if (mem_ready) begin
                    next_state = st_finish;
                end
            end
            st_finish: begin
                next_state = st_idle;
            end
            default: begin
                next_state = st_idle;
            end
        endcase
    end

    // request capture, only on an accepted start
    always_ff @(posedge clk) begin
        if (state == st_idle && start) begin
            cur_req <= req;
        end
    end

    // raw memory value, zero-extended by the memory for .W
    always_ff @(posedge clk) begin
        if (state == st_wait_read && mem_ready) begin
            loaded_value <= mem_rdata;
        end
    end

    assign ld_s  = is_word ? {{32{loaded_value[31]}}, loaded_value[31:0]} : loaded_value;
    assign src_s = is_word ? {{32{cur_req.src[31]}}, cur_req.src[31:0]} : cur_req.src;
    assign ld_u  = is_word ? {32'b0, loaded_value[31:0]} : loaded_value;
    assign src_u = is_word ? {32'b0, cur_req.src[31:0]} : cur_req.src;

    always_comb begin
        amo_calc = loaded_value;    // unknown op writes back unchanged
        case (cur_req.op)
            amo_pkg::amo_swap: amo_calc = cur_req.src;
            amo_pkg::amo_add:  amo_calc = loaded_value + cur_req.src;
            amo_pkg::amo_xor:  amo_calc = loaded_value ^ cur_req.src;
            amo_pkg::amo_and:  amo_calc = loaded_value & cur_req.src;
            amo_pkg::amo_or:   amo_calc = loaded_value | cur_req.src;
            amo_pkg::amo_min:  amo_calc = (ld_s < src_s) ? loaded_value : cur_req.src;
            amo_pkg::amo_max:  amo_calc = (ld_s > src_s) ? loaded_value : cur_req.src;
            amo_pkg::amo_minu: amo_calc = (ld_u < src_u) ? loaded_value : cur_req.src;
            amo_pkg::amo_maxu: amo_calc = (ld_u > src_u) ? loaded_value : cur_req.src;
            default:           amo_calc = loaded_value;
        endcase
    end

    always_ff @(posedge clk) begin
        if (state == st_compute) begin
            amo_wdata <= amo_calc;
        end
    end

    // memory request, req stays high across read and wait states
    always_comb begin
        mem       = '0;
        mem.addr  = cur_req.addr;
        mem.size  = cur_req.size;
        mem.wdata = is_sc ? cur_req.src : amo_wdata;
        case (state)
            st_read, st_wait_read: begin
                mem.req = 1'b1;
            end
            st_write, st_wait_write: begin
                mem.req = 1'b1;
                mem.we  = 1'b1;
            end
            default: begin
                mem.req = 1'b0;
            end
        endcase
    end

    // reservation strobes, both in the read ready cycle
    always_comb begin
        rsv          = '0;
        rsv.addr     = cur_req.addr;
        rsv.lr_valid = (state == st_wait_read) && mem_ready && is_lr;
        rsv.sc_valid = (state == st_wait_read) && mem_ready && is_sc;
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            result <= '0;
        end else if (state == st_wait_read && mem_ready) begin
            if (is_sc) begin
                result <= sc_success ? 64'd0 : 64'd1;
            end else if (is_word) begin
                result <= {{32{mem_rdata[31]}}, mem_rdata[31:0]};
            end else begin
                result <= mem_rdata;
            end
        end
    end

    assign busy = (state != st_idle);
    assign done = (state == st_finish);   // busy drops on the next cycle too

endmodule

//--- source/reservation_station.sv
//********************
// one LR reservation, doubleword granule
// any completed write to the granule drops it
//********************
`timescale 1ns/1ps

module reservation_station (
    input  logic                clk,
    input  logic                reset,
    input  amo_pkg::rsv_req_t   rsv,
    input  amo_pkg::mem_req_t   mem,
    input  logic                mem_ready,
    output logic                sc_success
);

    logic                         rsv_valid;
    logic [amo_pkg::xlen-1:3]     rsv_granule;   // address bits above 2
    logic                         write_hit;

    // snooped write completing on the reserved granule
    assign write_hit = mem.req && mem.we && mem_ready &&
                       (mem.addr[amo_pkg::xlen-1:3] == rsv_granule);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rsv_valid <= 1'b0;
        end else if (rsv.lr_valid) begin
            rsv_valid <= 1'b1;
        end else if (rsv.sc_valid || write_hit) begin
            // SC consumes the reservation either way
            rsv_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rsv.lr_valid) begin
            rsv_granule <= rsv.addr[amo_pkg::xlen-1:3];
        end
    end

    // combinational, sampled by the unit in the SC read ready cycle
    assign sc_success = rsv_valid && (rsv.addr[amo_pkg::xlen-1:3] == rsv_granule);

endmodule

//--- source/data_memory.sv
//********************
// single port, doubleword wide, fixed latency MEM_LATENCY >= 1
// address bits above the array depth are ignored
//********************
`timescale 1ns/1ps

module data_memory #(
    parameter int DEPTH_WORDS = 64,
    parameter int MEM_LATENCY = 2
) (
    input  logic                          clk,
    input  logic                          reset,
    input  amo_pkg::mem_req_t             mem,
    output logic [amo_pkg::xlen-1:0]      mem_rdata,
    output logic                          mem_ready
);

    localparam int aw = (DEPTH_WORDS > 1) ? $clog2(DEPTH_WORDS) : 1;
    localparam int cw = $clog2(MEM_LATENCY + 1);

    logic [amo_pkg::xlen-1:0] mem_array [DEPTH_WORDS];

    logic [aw-1:0]             idx;
    logic [cw-1:0]             wait_cnt;     // cycles since the access began
    logic [amo_pkg::xlen-1:0]  rd_dword;
    logic                      is_word;

    assign idx     = mem.addr[aw+2:3];
    assign is_word = (mem.size == amo_pkg::size_w);

    // ready in the MEM_LATENCY-th cycle after the first req cycle
    assign mem_ready = mem.req && (wait_cnt == cw'(MEM_LATENCY));

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wait_cnt <= '0;
        end else if (!mem.req || mem_ready) begin
            wait_cnt <= '0;   // held req restarts next cycle
        end else begin
            wait_cnt <= wait_cnt + 1'b1;
        end
    end

    assign rd_dword = mem_array[idx];

    // word reads zero-extended, bit 2 picks the half
    always_comb begin
        if (is_word) begin
            if (mem.addr[2]) begin
                mem_rdata = {32'b0, rd_dword[63:32]};
            end else begin
                mem_rdata = {32'b0, rd_dword[31:0]};
            end
        end else begin
            mem_rdata = rd_dword;
        end
    end

    // write lands at the end of the ready cycle
    always_ff @(posedge clk) begin
        if (mem_ready && mem.we) begin
            if (!is_word) begin
                mem_array[idx] <= mem.wdata;
            end else if (mem.addr[2]) begin
                mem_array[idx][63:32] <= mem.wdata[31:0];
            end else begin
                mem_array[idx][31:0] <= mem.wdata[31:0];
            end
        end
    end

endmodule

//--- source/atomic_subsystem.sv
//********************
// atomic unit, reservation station and data memory
// start ignored while busy; result held until next start
//********************
`timescale 1ns/1ps

module atomic_subsystem #(
    parameter int DEPTH_WORDS = 64,
    parameter int MEM_LATENCY = 2
) (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          start,
    input  amo_pkg::atomic_req_t          req,
    output logic [amo_pkg::xlen-1:0]      result,
    output logic                          done,
    output logic                          busy
);

    amo_pkg::mem_req_t          mem;
    amo_pkg::rsv_req_t          rsv;
    logic [amo_pkg::xlen-1:0]   mem_rdata;
    logic                       mem_ready;
    logic                       sc_success;

    atomic_unit unit_i (
        .clk        (clk),
        .reset      (reset),
        .start      (start),
        .req        (req),
        .mem_rdata  (mem_rdata),
        .mem_ready  (mem_ready),
        .sc_success (sc_success),
        .mem        (mem),
        .rsv        (rsv),
        .result     (result),
        .done       (done),
        .busy       (busy)
    );

    // snoops the memory request for conflicting writes
    reservation_station station_i (
        .clk        (clk),
        .reset      (reset),
        .rsv        (rsv),
        .mem        (mem),
        .mem_ready  (mem_ready),
        .sc_success (sc_success)
    );

    data_memory #(
        .DEPTH_WORDS (DEPTH_WORDS),
        .MEM_LATENCY (MEM_LATENCY)
    ) memory_i (
        .clk        (clk),
        .reset      (reset),
        .mem        (mem),
        .mem_rdata  (mem_rdata),
        .mem_ready  (mem_ready)
    );

endmodule

//--- sim/atomic_subsystem_properties.sv
//********************
// bound into atomic_subsystem, sampled on rising clk
//********************
`timescale 1ns/1ps

module atomic_subsystem_properties (
    input logic              clk,
    input logic              reset,
    input logic              done,
    input logic              busy,
    input amo_pkg::mem_req_t mem,
    input logic              mem_ready
);

    int unsigned fail_count = 0;   // summed into the testbench error count

    done_one_cycle: assert property (@(posedge clk) disable iff (reset) done |=> !done)
        else begin
            $error("done stayed high for more than one cycle");
            fail_count++;
        end

    // busy drops right after the done cycle
    done_ends_busy: assert property (@(posedge clk) disable iff (reset) done |=> $fell(busy))
        else begin
            $error("busy did not fall after done");
            fail_count++;
        end

    idle_no_req: assert property (@(posedge clk) disable iff (reset) !busy |-> !mem.req)
        else begin
            $error("memory request while the unit is idle");
            fail_count++;
        end

    ready_needs_req: assert property (@(posedge clk) disable iff (reset) mem_ready |-> mem.req)
        else begin
            $error("mem_ready without a memory request");
            fail_count++;
        end

endmodule

bind atomic_subsystem atomic_subsystem_properties props_i (
    .clk       (clk),
    .reset     (reset),
    .done      (done),
    .busy      (busy),
    .mem       (mem),
    .mem_ready (mem_ready)
);

//--- sim/atomic_subsystem_tb.sv
//********************
// directed tests checked against a doubleword model of the memory
// memory powers up unknown, so first touches use unchecked AMOSWAP.D
//********************
`timescale 1ns/1ps

module atomic_subsystem_tb;

    localparam int clk_period      = 20;
    localparam int mem_latency     = 2;
    localparam int amo_cycles      = 4 + 2 * mem_latency;
    localparam int op_count        = 160;   // upper bound over all tests
    localparam int watchdog_cycles = 8 + op_count * (amo_cycles + 4) + 200;

    logic                      clk = 1'b0;
    logic                      reset;
    logic                      start;
    amo_pkg::atomic_req_t      req;
    logic [amo_pkg::xlen-1:0]  result;
    logic                      done;
    logic                      busy;

    logic [63:0]  model_mem [64];
    bit           model_known [64];   // granule written by a .D op
    bit           model_rsv_valid;
    logic [63:3]  model_rsv_granule;

    integer seed       = 32'hcea4_8449;
    int     errors     = 0;
    int     ops_issued = 0;
    int     tests_run  = 0;

    atomic_subsystem #(
        .DEPTH_WORDS (64),
        .MEM_LATENCY (mem_latency)
    ) dut_i (
        .clk    (clk),
        .reset  (reset),
        .start  (start),
        .req    (req),
        .result (result),
        .done   (done),
        .busy   (busy)
    );

    always #(clk_period / 2) clk = ~clk;

    task automatic report_mismatch(input string name, input logic [63:0] got,
                                   input logic [63:0] exp);
        $display("Mismatch at %0d ns: %s = %h, expected %h", $time, name, got, exp);
        errors++;
    endtask

    task automatic end_test(input string name, input int base);
        tests_run++;
        $display("%-12s finished with %0d errors", name, errors - base);
    endtask

    // pulse start, wait for done and return result; called on a falling edge
    task automatic issue_op(input amo_pkg::amo_op_e op, input amo_pkg::amo_size_e size,
                            input logic [63:0] addr, input logic [63:0] src,
                            output logic [63:0] got);
        int waited;
        req.op   = op;
        req.size = size;
        req.addr = addr;
        req.src  = src;
        start    = 1'b1;
        @(negedge clk);
        start  = 1'b0;
        waited = 0;
        while (!done && waited < 4 * amo_cycles) begin
            @(negedge clk);
            waited++;
        end
        if (!done) begin
            $display("Error at %0d ns: no done within %0d cycles for %s",
                     $time, waited, op.name());
            errors++;
        end
        got = result;
        ops_issued++;
        @(negedge clk);   // step past the done cycle
    endtask

    // applies one operation to the model, returns the expected result
    task automatic model_apply(input amo_pkg::amo_op_e op, input amo_pkg::amo_size_e size,
                               input logic [63:0] addr, input logic [63:0] src,
                               output logic [63:0] exp_res, output bit exp_known);
        int          idx;
        bit          word;
        bit          hit;
        bit          do_write;
        logic [63:0] old_d;
        logic [63:0] new_d;
        logic [31:0] old_w;
        logic [31:0] src_w;
        logic [31:0] new_w;
        idx       = int'(addr[8:3]);
        word      = (size == amo_pkg::size_w);
        old_d     = model_mem[idx];
        old_w     = addr[2] ? old_d[63:32] : old_d[31:0];
        src_w     = src[31:0];
        new_d     = src;
        new_w     = src_w;
        hit       = model_rsv_valid && (model_rsv_granule == addr[63:3]);
        do_write  = (op != amo_pkg::amo_lr);
        exp_known = model_known[idx];
        exp_res   = word ? {{32{old_w[31]}}, old_w} : old_d;
        case (op)
            amo_pkg::amo_lr: begin
                model_rsv_valid   = 1'b1;
                model_rsv_granule = addr[63:3];
            end
            amo_pkg::amo_sc: begin
                exp_res         = hit ? 64'd0 : 64'd1;
                exp_known       = 1'b1;
                model_rsv_valid = 1'b0;   // consumed either way
                do_write        = hit;
            end
            amo_pkg::amo_add: begin
                new_d = old_d + src;
                new_w = old_w + src_w;
            end
            amo_pkg::amo_xor: begin
                new_d = old_d ^ src;
                new_w = old_w ^ src_w;
            end
            amo_pkg::amo_and: begin
                new_d = old_d & src;
                new_w = old_w & src_w;
            end
            amo_pkg::amo_or: begin
                new_d = old_d | src;
                new_w = old_w | src_w;
            end
            amo_pkg::amo_min: begin
                new_d = ($signed(old_d) < $signed(src)) ? old_d : src;
                new_w = ($signed(old_w) < $signed(src_w)) ? old_w : src_w;
            end
            amo_pkg::amo_max: begin
                new_d = ($signed(old_d) > $signed(src)) ? old_d : src;
                new_w = ($signed(old_w) > $signed(src_w)) ? old_w : src_w;
            end
            amo_pkg::amo_minu: begin
                new_d = (old_d < src) ? old_d : src;
                new_w = (old_w < src_w) ? old_w : src_w;
            end
            amo_pkg::amo_maxu: begin
                new_d = (old_d > src) ? old_d : src;
                new_w = (old_w > src_w) ? old_w : src_w;
            end
            default: ;   // swap stores src
        endcase
        if (do_write) begin
            if (!word) begin
                model_mem[idx]   = new_d;
                model_known[idx] = 1'b1;
            end else if (addr[2]) begin
                model_mem[idx][63:32] = new_w;
            end else begin
                model_mem[idx][31:0] = new_w;
            end
            if (model_rsv_valid && model_rsv_granule == addr[63:3]) begin
                model_rsv_valid = 1'b0;
            end
        end
    endtask

    task automatic run_and_check(input amo_pkg::amo_op_e op, input amo_pkg::amo_size_e size,
                                 input logic [63:0] addr, input logic [63:0] src,
                                 output logic [63:0] got);
        logic [63:0] exp_res;
        bit          exp_known;
        model_apply(op, size, addr, src, exp_res, exp_known);
        issue_op(op, size, addr, src, got);
        if (exp_known && got !== exp_res) begin
            report_mismatch($sformatf("result of %s", op.name()), got, exp_res);
        end
    endtask

    task automatic check_idle_after_reset();
        int base;
        base = errors;
        if (busy !== 1'b0) report_mismatch("busy", 64'(busy), 64'd0);
        if (done !== 1'b0) report_mismatch("done", 64'(done), 64'd0);
        repeat (5) begin
            @(negedge clk);
            if (done !== 1'b0) report_mismatch("done before start", 64'(done), 64'd0);
        end
        end_test("reset", base);
    endtask

    task automatic swap_then_lr();
        logic [63:0] got;
        logic [63:0] src;
        int          base;
        base = errors;
        for (int g = 0; g < 8; g++) begin
            src = {$random(seed), $random(seed)};
            run_and_check(amo_pkg::amo_swap, amo_pkg::size_d, 64'(g * 8), src, got);
        end
        for (int g = 0; g < 6; g++) begin
            src = {$random(seed), $random(seed)};
            run_and_check(amo_pkg::amo_swap, amo_pkg::size_d, 64'(g * 8), src, got);
            run_and_check(amo_pkg::amo_lr, amo_pkg::size_d, 64'(g * 8), 64'd0, got);
            if (got !== src) report_mismatch("lr after swap", got, src);
        end
        end_test("swap_lr", base);
    endtask

    task automatic arith_logic_amos();
        amo_pkg::amo_op_e logic_ops [3] = '{amo_pkg::amo_xor, amo_pkg::amo_and,
                                            amo_pkg::amo_or};
        logic [63:0]      got;
        int               base;
        base = errors;
        run_and_check(amo_pkg::amo_swap, amo_pkg::size_d, 64'h10, 64'h20, got);
        run_and_check(amo_pkg::amo_add, amo_pkg::size_d, 64'h10, 64'hffff_ffff_ffff_fff0, got);
        run_and_check(amo_pkg::amo_lr, amo_pkg::size_d, 64'h10, 64'd0, got);
        if (got !== 64'h10) report_mismatch("add wrap", got, 64'h10);
        for (int k = 0; k < 3; k++) begin
            run_and_check(logic_ops[k], amo_pkg::size_d, 64'h10,
                          {$random(seed), $random(seed)}, got);
            run_and_check(amo_pkg::amo_lr, amo_pkg::size_d, 64'h10, 64'd0, got);
        end
        end_test("arith_logic", base);
    endtask

    task automatic compare_amos();
        amo_pkg::amo_op_e cmp_ops [4]   = '{amo_pkg::amo_min, amo_pkg::amo_max,
                                            amo_pkg::amo_minu, amo_pkg::amo_maxu};
        logic [63:0]      init_vals [4] = '{64'h7fff_ffff_ffff_ffff, 64'h8000_0000_0000_0000,
                                            64'h0000_0001_7fff_ffff, 64'hffff_fffe_8000_0000};
        logic [63:0]      src_vals [4]  = '{64'h8000_0000_0000_0000, 64'hffff_ffff_ffff_ffff,
                                            64'h1234_5678_8000_0000, 64'h0000_0000_7fff_ffff};
        logic [63:0]      got;
        int               base;
        base = errors;
        for (int k = 0; k < 4; k++) begin
            for (int p = 0; p < 2; p++) begin
                run_and_check(amo_pkg::amo_swap, amo_pkg::size_d, 64'h18, init_vals[p], got);
                run_and_check(cmp_ops[k], amo_pkg::size_d, 64'h18, src_vals[p], got);
                run_and_check(amo_pkg::amo_lr, amo_pkg::size_d, 64'h18, 64'd0, got);
                // p picks the half; the LR.D shows the other half untouched
                run_and_check(amo_pkg::amo_swap, amo_pkg::size_d, 64'h20, init_vals[p + 2], got);
                run_and_check(cmp_ops[k], amo_pkg::size_w, 64'h20 + 64'(p * 4),
                              src_vals[p + 2], got);
                run_and_check(amo_pkg::amo_lr, amo_pkg::size_d, 64'h20, 64'd0, got);
            end
        end
        end_test("compare", base);
    endtask

    task automatic lr_sc_pairs();
        logic [63:0] got;
        int          base;
        base = errors;
        run_and_check(amo_pkg::amo_lr, amo_pkg::size_d, 64'h28, 64'd0, got);
        run_and_check(amo_pkg::amo_sc, amo_pkg::size_d, 64'h28, 64'h1111_2222_3333_4444, got);
        if (got !== 64'd0) report_mismatch("sc after lr", got, 64'd0);
        run_and_check(amo_pkg::amo_sc, amo_pkg::size_d, 64'h28, 64'h5555_6666_7777_8888, got);
        if (got !== 64'd1) report_mismatch("second sc", got, 64'd1);
        run_and_check(amo_pkg::amo_lr, amo_pkg::size_d, 64'h28, 64'd0, got);
        if (got !== 64'h1111_2222_3333_4444) report_mismatch("sc data", got, 64'h1111_2222_3333_4444);
        run_and_check(amo_pkg::amo_add, amo_pkg::size_d, 64'h28, 64'd1, got);
        run_and_check(amo_pkg::amo_sc, amo_pkg::size_d, 64'h28, 64'd0, got);
        if (got !== 64'd1) report_mismatch("sc after amo", got, 64'd1);
        run_and_check(amo_pkg::amo_lr, amo_pkg::size_d, 64'h28, 64'd0, got);
        run_and_check(amo_pkg::amo_sc, amo_pkg::size_d, 64'h30, 64'd0, got);
        if (got !== 64'd1) report_mismatch("sc other granule", got, 64'd1);
        run_and_check(amo_pkg::amo_lr, amo_pkg::size_w, 64'h2c, 64'd0, got);
        run_and_check(amo_pkg::amo_sc, amo_pkg::size_w, 64'h2c, 64'h9abc_def0_8765_4321, got);
        run_and_check(amo_pkg::amo_lr, amo_pkg::size_d, 64'h28, 64'd0, got);
        end_test("lr_sc", base);
    endtask

    task automatic random_sequence();
        amo_pkg::amo_op_e   op_list [11] = '{amo_pkg::amo_add, amo_pkg::amo_swap,
            amo_pkg::amo_lr, amo_pkg::amo_sc, amo_pkg::amo_xor, amo_pkg::amo_or,
            amo_pkg::amo_and, amo_pkg::amo_min, amo_pkg::amo_max, amo_pkg::amo_minu,
            amo_pkg::amo_maxu};
        amo_pkg::amo_size_e size;
        logic [63:0]        got;
        logic [63:0]        addr;
        logic [63:0]        src;
        logic [63:0]        exp_res;
        bit                 exp_known;
        int                 pick;
        int                 done_count;
        int                 base;
        base = errors;
        for (int n = 0; n < 40; n++) begin
            pick = $unsigned($random(seed)) % 11;
            size = ($random(seed) & 1) ? amo_pkg::size_w : amo_pkg::size_d;
            addr = 64'(($unsigned($random(seed)) % 8) * 8);
            if ((size == amo_pkg::size_w) && (($random(seed) & 1) != 0)) begin
                addr = addr + 64'd4;
            end
            src = {$random(seed), $random(seed)};
            run_and_check(op_list[pick], size, addr, src, got);
        end
        // start held into the busy cycle with a different request
        src = {$random(seed), $random(seed)};
        model_apply(amo_pkg::amo_xor, amo_pkg::size_d, 64'h8, src, exp_res, exp_known);
        req.op   = amo_pkg::amo_xor;
        req.size = amo_pkg::size_d;
        req.addr = 64'h8;
        req.src  = src;
        start    = 1'b1;
        @(negedge clk);
        req.op   = amo_pkg::amo_swap;
        req.addr = 64'h38;
        if (!busy) begin
            $display("Error at %0d ns: busy low after an accepted start", $time);
            errors++;
        end
        @(negedge clk);
        start      = 1'b0;
        done_count = 0;
        for (int c = 0; c < 3 * amo_cycles; c++) begin
            if (done) done_count++;
            @(negedge clk);
        end
        ops_issued++;
        if (done_count != 1) begin
            $display("Error at %0d ns: %0d done pulses for one accepted start", $time, done_count);
            errors++;
        end
        if (exp_known && result !== exp_res) report_mismatch("result of busy xor", result, exp_res);
        run_and_check(amo_pkg::amo_lr, amo_pkg::size_d, 64'h38, 64'd0, got);
        end_test("random", base);
    endtask

    initial begin
        reset = 1'b1;
        start = 1'b0;
        req   = '0;
        repeat (8) @(negedge clk);
        reset = 1'b0;
        check_idle_after_reset();
        swap_then_lr();
        arith_logic_amos();
        compare_amos();
        lr_sc_pairs();
        random_sequence();
        errors += int'(dut_i.props_i.fail_count);
        $display("%0d tests, %0d operations, %0d errors", tests_run, ops_issued, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    // watchdog sized from the op count and the AMO latency
    initial begin
        #(watchdog_cycles * clk_period);
        $display("Error: watchdog expired after %0d cycles, a test is stuck", watchdog_cycles);
        $display("TEST FAIL");
        $finish;
    end

endmodule

//--- atomic_subsystem.f
source/amo_pkg.sv
source/atomic_unit.sv
source/reservation_station.sv
source/data_memory.sv
source/atomic_subsystem.sv
sim/atomic_subsystem_properties.sv
sim/atomic_subsystem_tb.sv

//--- run_sim.sh
#!/bin/sh
# compile with Verilator and run; passes only when the pass line is printed
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module atomic_subsystem_tb \
    -f atomic_subsystem.f \
    -o atomic_subsystem_sim

# error limit raised so assertion failures still reach the summary
./obj_dir/atomic_subsystem_sim +verilator+error+limit+1000 | tee /dev/stderr | grep -q "TEST PASS"
echo "simulation passed"
